// File: common/icache_pkg.sv
// shared widths, line geometry and packed structs for the instruction cache
// referenced by scoped name from every cache module

package icache_pkg;

    // ------------------------------
    // address split
    // ------------------------------
    localparam int unsigned ADDR_SIZE     = 40;                       // vaddr and paddr
    localparam int unsigned IDX_BITS_SIZE = 12;                       // page offset
    localparam int unsigned VPN_BITS_SIZE = ADDR_SIZE - IDX_BITS_SIZE;
    localparam int unsigned PPN_BITS_SIZE = ADDR_SIZE - IDX_BITS_SIZE; // also the tag

    // ------------------------------
    // line geometry
    // ------------------------------
    localparam int unsigned LINE_BYTES     = 32;
    localparam int unsigned LINE_BITS      = LINE_BYTES * 8;
    localparam int unsigned OFFSET_WIDTH   = $clog2(LINE_BYTES);
    localparam int unsigned SET_IDX_WIDTH  = IDX_BITS_SIZE - OFFSET_WIDTH; // index fits in page
    localparam int unsigned N_SETS         = 1 << SET_IDX_WIDTH;
    localparam int unsigned FETCH_WIDTH    = 128;
    localparam int unsigned WORDS_PER_LINE = LINE_BITS / FETCH_WIDTH;

    typedef logic [LINE_BITS-1:0]     line_t;
    typedef logic [PPN_BITS_SIZE-1:0] tag_t;

    // ------------------------------
    // core side
    // ------------------------------
    typedef struct packed {
        logic [VPN_BITS_SIZE-1:0] vpn;
        logic [IDX_BITS_SIZE-1:0] idx;
    } ireq_t;

    typedef struct packed {
        logic [FETCH_WIDTH-1:0] data;
        logic [ADDR_SIZE-1:0]   vaddr;
        logic                   xcpt;   // translation fault, data is zero
    } iresp_t;

    // ------------------------------
    // MMU side
    // ------------------------------
    // miss means the MMU has no answer yet and the
    // request has to be sent again
    typedef struct packed {
        logic                     miss;
        logic [PPN_BITS_SIZE-1:0] ppn;
        logic                     xcpt;
    } mmu_tresp_t;

endpackage

// File: design/icache_sram.sv
// single-port array with registered read, used for the tag ways and the line ways
// the entry type is chosen per instance

`timescale 1ns/1ps

module icache_sram #(
    parameter int unsigned DEPTH   = 128,
    parameter type         ENTRY_T = logic [31:0]
) (
    input  logic                     clk_i,
    input  logic                     en_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  ENTRY_T                   wdata_i,
    output ENTRY_T                   rdata_o
);

    ENTRY_T mem [DEPTH];

    // read data holds until the next read
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

// File: dv/icache_assert.sv
// concurrent checks on the cache controller handshake outputs
// bound into every icache_ctrl instance

`timescale 1ns/1ps

module icache_assert (
    input logic clk_i,
    input logic rst_n_i,
    input logic ready_i,
    input logic resp_valid_i,
    input logic fill_req_i,
    input logic fill_resp_i
);

    int unsigned fail_count = 0;   // read by the testbench at the end

    // no new request while a line is outstanding
    a_busy_in_fill: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fill_req_i |-> !ready_i)
        else begin
            $error("ready high while a fill request is pending");
            fail_count++;
        end

    a_resp_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        resp_valid_i |=> !resp_valid_i)     // single-cycle pulse
        else begin
            $error("response valid held for two cycles");
            fail_count++;
        end

    // fill request is a level until the fill port answers
    a_fill_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (fill_req_i && !fill_resp_i) |=> fill_req_i)
        else begin
            $error("fill request dropped before the fill pulse");
            fail_count++;
        end

endmodule

bind icache_ctrl icache_assert u_ctrl_assert (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ready_i      (ready_o),
    .resp_valid_i (resp_valid_o),
    .fill_req_i   (ifill_req_valid_o),
    .fill_resp_i  (ifill_resp_valid_i)
);

// File: dv/icache_tb.sv
// testbench for the instruction cache with a stimulus table and MMU and fill port models
// run with the file list, top module icache_tb

`timescale 1ns/1ps

module icache_tb;

    localparam int N_ENTRIES = 19;

    typedef struct packed {
        logic                                 flush;
        logic [icache_pkg::VPN_BITS_SIZE-1:0] vpn;
        logic [icache_pkg::IDX_BITS_SIZE-1:0] idx;
        logic [icache_pkg::PPN_BITS_SIZE-1:0] ppn;
        logic [3:0]                           mmu_miss;   // miss answers before the final one
        logic                                 xcpt;
        logic                                 fill;       // a line fill is expected
    } entry_t;

    logic                                 clk_i;
    logic                                 rst_n_i;
    logic                                 flush_i;
    logic                                 ireq_valid_i;
    icache_pkg::ireq_t                    ireq_i;
    logic                                 iresp_ready_o;
    logic                                 iresp_valid_o;
    icache_pkg::iresp_t                   iresp_o;
    logic                                 treq_valid_o;
    logic [icache_pkg::VPN_BITS_SIZE-1:0] treq_vpn_o;
    icache_pkg::mmu_tresp_t               mmu_tresp_i;
    logic                                 ifill_req_valid_o;
    logic [icache_pkg::ADDR_SIZE-1:0]     ifill_req_paddr_o;
    logic                                 ifill_resp_valid_i;
    icache_pkg::line_t                    ifill_resp_data_i;

    entry_t      tbl [N_ENTRIES];
    entry_t      cur;
    int          mmu_answers;
    int          fill_cnt;
    bit          fill_busy;
    int unsigned fill_wait;

    icache_top #(.N_WAYS(4)) u_icache_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ------------------------------
    // reference rules
    // ------------------------------
    function automatic entry_t make_entry(input logic f, input logic [27:0] vpn,
                                          input logic [11:0] idx, input logic [27:0] ppn,
                                          input logic [3:0] miss, input logic x, input logic fl);
        return '{flush: f, vpn: vpn, idx: idx, ppn: ppn, mmu_miss: miss, xcpt: x, fill: fl};
    endfunction

    function automatic logic [icache_pkg::ADDR_SIZE-1:0] line_paddr(input entry_t e);
        return {e.ppn, e.idx[11:5], 5'b0};
    endfunction

    // each 32-bit word holds its own byte address xor a fixed pattern
    function automatic icache_pkg::line_t fill_line(input logic [icache_pkg::ADDR_SIZE-1:0] pa);
        icache_pkg::line_t line;
        for (int k = 0; k < 8; k++) begin
            line[32*k +: 32] = (pa[31:0] + 32'(4 * k)) ^ 32'h5a5a_0000;
        end
        return line;
    endfunction

    function automatic icache_pkg::iresp_t expected_resp(input entry_t e);
        icache_pkg::iresp_t               r;
        logic [icache_pkg::ADDR_SIZE-1:0] pa;
        logic [31:0]                      base;
        pa      = line_paddr(e);
        base    = pa[31:0] + (e.idx[4] ? 32'd16 : 32'd0);   // idx bit 4 picks the half
        r.vaddr = {e.vpn, e.idx};
        r.xcpt  = e.xcpt;
        r.data  = '0;
        if (!e.xcpt) begin
            for (int j = 0; j < 4; j++) begin
                r.data[32*j +: 32] = (base + 32'(4 * j)) ^ 32'h5a5a_0000;
            end
        end
        return r;
    endfunction

    // ------------------------------
    // checks
    // ------------------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_resp(input icache_pkg::iresp_t got, input icache_pkg::iresp_t exp);
        if (got.data !== exp.data) begin
            stop_on_error($sformatf("Mismatch at %0t: iresp_o.data got %h expected %h",
                                    $time, got.data, exp.data));
        end else if (got.vaddr !== exp.vaddr) begin
            stop_on_error($sformatf("Mismatch at %0t: iresp_o.vaddr got %h expected %h",
                                    $time, got.vaddr, exp.vaddr));
        end else if (got.xcpt !== exp.xcpt) begin
            stop_on_error($sformatf("Mismatch at %0t: iresp_o.xcpt got %b expected %b",
                                    $time, got.xcpt, exp.xcpt));
        end
    endtask

    task automatic check_paddr(input logic [icache_pkg::ADDR_SIZE-1:0] got,
                               input logic [icache_pkg::ADDR_SIZE-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t: ifill_req_paddr_o got %h expected %h",
                                    $time, got, exp));
        end
    endtask

    task automatic check_vpn(input logic [icache_pkg::VPN_BITS_SIZE-1:0] got,
                             input logic [icache_pkg::VPN_BITS_SIZE-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t: treq_vpn_o got %h expected %h",
                                    $time, got, exp));
        end
    endtask

    task automatic check_fill(input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t: ifill_req_valid_o seen got %b expected %b",
                                    $time, got, exp));
        end
    endtask

    // ------------------------------
    // MMU and fill port models
    // ------------------------------
    // one answer per translation request and a wrong ppn while missing
    always @(posedge clk_i) begin
        if (ireq_valid_i && iresp_ready_o) begin
            mmu_answers = 0;
        end
        if (treq_valid_o) begin
            check_vpn(treq_vpn_o, cur.vpn);
            if (mmu_answers < int'(cur.mmu_miss)) begin
                mmu_tresp_i <= '{miss: 1'b1, ppn: ~cur.ppn, xcpt: 1'b0};
            end else begin
                mmu_tresp_i <= '{miss: 1'b0, ppn: cur.ppn, xcpt: cur.xcpt};
            end
            mmu_answers++;
        end
    end

    always @(posedge clk_i) begin
        ifill_resp_valid_i <= 1'b0;
        if (!ifill_resp_valid_i && ifill_req_valid_o) begin
            if (!fill_busy) begin
                fill_busy = 1'b1;
                fill_wait = $urandom % 4;
                fill_cnt++;
                check_paddr(ifill_req_paddr_o, line_paddr(cur));
            end
            if (fill_wait == 0) begin
                ifill_resp_valid_i <= 1'b1;
                ifill_resp_data_i  <= fill_line(ifill_req_paddr_o);
                fill_busy = 1'b0;
            end else begin
                fill_wait--;
            end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic wait_ready();
        do @(negedge clk_i); while (!iresp_ready_o);
    endtask

    task automatic do_flush();
        wait_ready();
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        wait_ready();
    endtask

    task automatic run_request(input entry_t e);
        icache_pkg::iresp_t exp;
        exp = expected_resp(e);
        wait_ready();
        fill_cnt = 0;
        @(posedge clk_i);
        ireq_valid_i <= 1'b1;
        ireq_i       <= '{vpn: e.vpn, idx: e.idx};
        @(posedge clk_i);
        ireq_valid_i <= 1'b0;
        do @(negedge clk_i); while (!iresp_valid_o);
        check_resp(iresp_o, exp);
        check_fill(fill_cnt != 0, e.fill);
    endtask

    initial begin
        void'($urandom(32'h39fd39de));
        rst_n_i            = 1'b0;
        flush_i            = 1'b0;
        ireq_valid_i       = 1'b0;
        ireq_i             = '0;
        mmu_tresp_i        = '0;
        ifill_resp_valid_i = 1'b0;
        ifill_resp_data_i  = '0;
        mmu_answers        = 0;
        fill_cnt           = 0;
        fill_busy          = 1'b0;
        fill_wait          = 0;
        cur                = '0;
        //                    flush vpn           idx      ppn       miss xcpt fill
        tbl[0]  = make_entry(1'b0, 28'h000_0123, 12'h040, 28'h00a_bc01, 0, 0, 1); // cold miss
        tbl[1]  = make_entry(1'b0, 28'h000_0123, 12'h050, 28'h00a_bc01, 0, 0, 0); // other half
        tbl[2]  = make_entry(1'b0, 28'h000_0123, 12'h04c, 28'h00a_bc01, 0, 0, 0);
        tbl[3]  = make_entry(1'b0, 28'h000_0200, 12'h3a0, 28'h077_7000, 3, 0, 1); // mmu retries
        tbl[4]  = make_entry(1'b0, 28'h000_0200, 12'h3b4, 28'h077_7000, 2, 0, 0);
        tbl[5]  = make_entry(1'b0, 28'h000_0300, 12'h100, 28'h012_3456, 0, 1, 0); // fault
        tbl[6]  = make_entry(1'b0, 28'h000_0301, 12'h040, 28'h00a_bc01, 1, 1, 0);
        tbl[7]  = make_entry(1'b0, 28'h001_0001, 12'h600, 28'h100_0001, 0, 0, 1); // set 0x30
        tbl[8]  = make_entry(1'b0, 28'h001_0002, 12'h610, 28'h100_0002, 0, 0, 1);
        tbl[9]  = make_entry(1'b0, 28'h001_0003, 12'h600, 28'h100_0003, 0, 0, 1);
        tbl[10] = make_entry(1'b0, 28'h001_0004, 12'h610, 28'h100_0004, 0, 0, 1);
        tbl[11] = make_entry(1'b0, 28'h001_0005, 12'h600, 28'h100_0005, 0, 0, 1); // evicts way 0
        tbl[12] = make_entry(1'b0, 28'h001_0002, 12'h600, 28'h100_0002, 0, 0, 0);
        tbl[13] = make_entry(1'b0, 28'h001_0003, 12'h610, 28'h100_0003, 0, 0, 0);
        tbl[14] = make_entry(1'b0, 28'h001_0004, 12'h600, 28'h100_0004, 0, 0, 0);
        tbl[15] = make_entry(1'b0, 28'h001_0001, 12'h610, 28'h100_0001, 0, 0, 1);
        tbl[16] = make_entry(1'b1, 28'h0,        12'h0,   28'h0,        0, 0, 0); // flush
        tbl[17] = make_entry(1'b0, 28'h000_0123, 12'h040, 28'h00a_bc01, 0, 0, 1);
        tbl[18] = make_entry(1'b0, 28'h000_0123, 12'h050, 28'h00a_bc01, 1, 0, 0);

        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;

        for (int i = 0; i < N_ENTRIES; i++) begin
            cur = tbl[i];
            if (cur.flush) begin
                do_flush();
            end else begin
                run_request(cur);
            end
        end
        repeat (4) @(posedge clk_i);   // let the last assertions settle

        if (u_icache_top.u_ctrl.u_ctrl_assert.fail_count != 0) begin
            stop_on_error("Controller assertions failed during the run");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

    // watchdog
    initial begin
        repeat (16 + N_ENTRIES * 200) @(posedge clk_i);
        stop_on_error("Timeout: the cache did not finish the stimulus table in time");
    end

endmodule

// File: icache/icache_checker.sv
// tag compare over all ways and fetch word select from the hitting line
// purely combinational, sits between the arrays and the response

`timescale 1ns/1ps

module icache_checker #(
    parameter int unsigned N_WAYS = 4
) (
    input  icache_pkg::tag_t                                 tags_i [N_WAYS],
    input  logic [N_WAYS-1:0]                                valid_bits_i,
    input  icache_pkg::line_t                                lines_i [N_WAYS],
    input  logic [icache_pkg::PPN_BITS_SIZE-1:0]             ppn_i,
    input  logic [$clog2(icache_pkg::WORDS_PER_LINE)-1:0]    word_sel_i,
    output logic [N_WAYS-1:0]                                hit_o,
    output logic [icache_pkg::FETCH_WIDTH-1:0]               data_o
);

    icache_pkg::line_t hit_line;

    // line viewed as fetch words
    logic [icache_pkg::WORDS_PER_LINE-1:0][icache_pkg::FETCH_WIDTH-1:0] words;

    // ------------------------------
    // compare
    // ------------------------------
    always_comb begin
        for (int w = 0; w < N_WAYS; w++) begin
            hit_o[w] = valid_bits_i[w] && (tags_i[w] == ppn_i);
        end
    end

    // ------------------------------
    // way and word select
    // ------------------------------
    // at most one way hits, so an or-mux is enough
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            if (hit_o[w]) begin
                hit_line = hit_line | lines_i[w];
            end
        end
    end

    assign words  = hit_line;
    assign data_o = words[word_sel_i];      // idx bit 4 picks the half

endmodule

// File: icache/icache_ctrl.sv
// cache control FSM: translation retries, compare, line fill, replay and flush
// drives ready, response valid, translation request and fill request

`timescale 1ns/1ps

module icache_ctrl #(
    parameter int unsigned N_WAYS = 4
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  logic              req_accept_i,       // valid and ready from the core side
    input  logic              mmu_miss_i,         // registered MMU answer
    input  logic              mmu_xcpt_i,
    input  logic [N_WAYS-1:0] hit_i,              // per-way hit from the checker
    input  logic              ifill_resp_valid_i,
    output logic              ready_o,
    output logic              rd_en_o,
    output logic              wr_en_o,
    output logic              flush_en_o,
    output logic              treq_valid_o,
    output logic              ifill_req_valid_o,
    output logic              resp_valid_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_TRANS,    // first MMU answer on its way
        S_CMP,      // MMU answer and arrays both valid
        S_FILL,     // waiting on the fill port
        S_WRITE,
        S_REPLAY,
        S_FLUSH
    } state_t;

    state_t state_q;
    state_t state_d;

    logic hit;
    logic cmp_done;     // translation resolved this cycle
    logic cmp_miss;     // resolved, no fault and no hit

    assign hit      = |hit_i;
    assign cmp_done = (state_q == S_CMP) && !mmu_miss_i;
    assign cmp_miss = cmp_done && !mmu_xcpt_i && !hit;

    // ------------------------------
    // outputs
    // ------------------------------
    assign ready_o    = (state_q == S_IDLE) && !flush_i;   // flush wins over a new request
    assign rd_en_o    = req_accept_i || (state_q == S_REPLAY);
    assign wr_en_o    = (state_q == S_WRITE);
    assign flush_en_o = (state_q == S_FLUSH);

    // also sent in S_TRANS, so that an MMU miss costs one cycle and not two
    assign treq_valid_o = req_accept_i
                       || (state_q == S_TRANS)
                       || ((state_q == S_CMP) && mmu_miss_i);

    // level from the compare cycle until the fill pulse
    assign ifill_req_valid_o = cmp_miss || (state_q == S_FILL);

    assign resp_valid_o = cmp_done && (mmu_xcpt_i || hit);

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (req_accept_i) begin
                    state_d = S_TRANS;
                end else if (flush_i) begin
                    state_d = S_FLUSH;
                end
            end
            S_TRANS: begin
                state_d = S_CMP;
            end
            S_CMP: begin
                if (cmp_miss) begin
                    state_d = S_FILL;
                end else if (cmp_done) begin
                    state_d = S_IDLE;
                end
            end
            S_FILL: begin
                if (ifill_resp_valid_i) begin
                    state_d = S_WRITE;
                end
            end
            S_WRITE: begin
                state_d = S_REPLAY;
            end
            S_REPLAY: begin
                state_d = S_CMP;    // filled line comes back as a hit
            end
            S_FLUSH: begin
                state_d = S_IDLE;
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: icache/icache_replace.sv
// per-set valid bits and victim choice for the fill write
// lowest invalid way first, otherwise the set's round-robin pointer

`timescale 1ns/1ps

module icache_replace #(
    parameter int unsigned N_WAYS = 4
) (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  logic [icache_pkg::SET_IDX_WIDTH-1:0]   set_i,
    input  logic                                   wr_en_i,
    input  logic                                   flush_en_i,
    output logic [N_WAYS-1:0]                      valid_bits_o,
    output logic [$clog2(N_WAYS)-1:0]              victim_way_o
);

    localparam int unsigned WAY_W = $clog2(N_WAYS);

    logic [icache_pkg::SET_IDX_WIDTH-1:0] set_q;
    logic [N_WAYS-1:0]                    valid_q  [icache_pkg::N_SETS];
    logic [WAY_W-1:0]                     rr_ptr_q [icache_pkg::N_SETS];
    logic [WAY_W-1:0]                     rr_ptr_next;

    assign valid_bits_o = valid_q[set_q];

    // walk down so the lowest invalid way is the last one taken
    always_comb begin
        victim_way_o = rr_ptr_q[set_q];
        for (int w = N_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[set_q][w]) begin
                victim_way_o = WAY_W'(w);
            end
        end
    end

    assign rr_ptr_next = (rr_ptr_q[set_q] == WAY_W'(N_WAYS - 1)) ? '0
                                                                 : rr_ptr_q[set_q] + 1'b1;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            set_q <= '0;
            for (int s = 0; s < icache_pkg::N_SETS; s++) begin
                valid_q[s]  <= '0;
                rr_ptr_q[s] <= '0;
            end
        end else begin
            set_q <= set_i;
            if (flush_en_i) begin
                for (int s = 0; s < icache_pkg::N_SETS; s++) begin
                    valid_q[s] <= '0;   // pointers keep their place
                end
            end else if (wr_en_i) begin
                valid_q[set_q][victim_way_o] <= 1'b1;
                rr_ptr_q[set_q]              <= rr_ptr_next;
            end
        end
    end

endmodule

// File: icache/icache_top.sv
// instruction cache top: VIPT lookup over N_WAYS ways, 128 sets of 32-byte lines
// holds the request and MMU answer, builds the fill address and the response

`timescale 1ns/1ps

module icache_top #(
    parameter int unsigned N_WAYS = 4
) (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  logic                                   flush_i,
    input  logic                                   ireq_valid_i,
    input  icache_pkg::ireq_t                      ireq_i,
    output logic                                   iresp_ready_o,
    output logic                                   iresp_valid_o,
    output icache_pkg::iresp_t                     iresp_o,
    output logic                                   treq_valid_o,
    output logic [icache_pkg::VPN_BITS_SIZE-1:0]   treq_vpn_o,
    input  icache_pkg::mmu_tresp_t                 mmu_tresp_i,
    output logic                                   ifill_req_valid_o,
    output logic [icache_pkg::ADDR_SIZE-1:0]       ifill_req_paddr_o,
    input  logic                                   ifill_resp_valid_i,
    input  icache_pkg::line_t                      ifill_resp_data_i
);

    localparam int unsigned WSEL_W = $clog2(icache_pkg::WORDS_PER_LINE);

    icache_pkg::ireq_t      req_q;
    icache_pkg::mmu_tresp_t mmu_q;
    icache_pkg::line_t      fill_line_q;
    icache_pkg::tag_t       way_tags  [N_WAYS];
    icache_pkg::line_t      way_lines [N_WAYS];

    logic                                 req_accept;
    logic                                 treq_q;       // an MMU answer is due this cycle
    logic                                 mmu_lock_q;   // final answer already held
    logic                                 mmu_capture;
    logic                                 rd_en;
    logic                                 wr_en;
    logic                                 flush_en;
    logic [N_WAYS-1:0]                    valid_bits;
    logic [N_WAYS-1:0]                    hit_vec;
    logic [$clog2(N_WAYS)-1:0]            victim_way;
    logic [icache_pkg::SET_IDX_WIDTH-1:0] set_addr;
    logic [icache_pkg::FETCH_WIDTH-1:0]   fetch_word;

    assign req_accept = ireq_valid_i && iresp_ready_o;

    // new request goes straight to the arrays, later reads use the held one
    assign set_addr   = req_accept ? ireq_i.idx[icache_pkg::IDX_BITS_SIZE-1:icache_pkg::OFFSET_WIDTH]
                                   : req_q.idx[icache_pkg::IDX_BITS_SIZE-1:icache_pkg::OFFSET_WIDTH];
    assign treq_vpn_o = req_accept ? ireq_i.vpn : req_q.vpn;

    // ------------------------------
    // held request and MMU answer
    // ------------------------------
    // the answer to the speculative request is dropped once a final ppn is held
    assign mmu_capture = treq_q && !mmu_lock_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            treq_q     <= 1'b0;
            mmu_lock_q <= 1'b0;
        end else begin
            treq_q <= treq_valid_o;
            if (req_accept) begin
                mmu_lock_q <= 1'b0;
            end else if (mmu_capture && !mmu_tresp_i.miss) begin
                mmu_lock_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_accept) begin
            req_q <= ireq_i;
        end
        if (mmu_capture) begin
            mmu_q <= mmu_tresp_i;
        end
        if (ifill_resp_valid_i) begin
            fill_line_q <= ifill_resp_data_i;   // written in the next cycle
        end
    end

    // ------------------------------
    // fill request and response
    // ------------------------------
    assign ifill_req_paddr_o = {mmu_q.ppn,
                                req_q.idx[icache_pkg::IDX_BITS_SIZE-1:icache_pkg::OFFSET_WIDTH],
                                {icache_pkg::OFFSET_WIDTH{1'b0}}};

    assign iresp_o.data  = mmu_q.xcpt ? '0 : fetch_word;
    assign iresp_o.vaddr = {req_q.vpn, req_q.idx};
    assign iresp_o.xcpt  = mmu_q.xcpt;

    icache_ctrl #(
        .N_WAYS             (N_WAYS)
    ) u_ctrl (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .flush_i            (flush_i),
        .req_accept_i       (req_accept),
        .mmu_miss_i         (mmu_q.miss),
        .mmu_xcpt_i         (mmu_q.xcpt),
        .hit_i              (hit_vec),
        .ifill_resp_valid_i (ifill_resp_valid_i),
        .ready_o            (iresp_ready_o),
        .rd_en_o            (rd_en),
        .wr_en_o            (wr_en),
        .flush_en_o         (flush_en),
        .treq_valid_o       (treq_valid_o),
        .ifill_req_valid_o  (ifill_req_valid_o),
        .resp_valid_o       (iresp_valid_o)
    );

    icache_replace #(
        .N_WAYS       (N_WAYS)
    ) u_replace (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .set_i        (set_addr),
        .wr_en_i      (wr_en),
        .flush_en_i   (flush_en),
        .valid_bits_o (valid_bits),
        .victim_way_o (victim_way)
    );

    // ------------------------------
    // tag and line arrays
    // ------------------------------
    for (genvar w = 0; w < N_WAYS; w++) begin : g_way
        logic way_we;

        assign way_we = wr_en && (victim_way == w);

        icache_sram #(
            .DEPTH   (icache_pkg::N_SETS),
            .ENTRY_T (icache_pkg::tag_t)
        ) u_tag (
            .clk_i   (clk_i),
            .en_i    (rd_en || way_we),
            .we_i    (way_we),
            .addr_i  (set_addr),
            .wdata_i (mmu_q.ppn),
            .rdata_o (way_tags[w])
        );

        icache_sram #(
            .DEPTH   (icache_pkg::N_SETS),
            .ENTRY_T (icache_pkg::line_t)
        ) u_line (
            .clk_i   (clk_i),
            .en_i    (rd_en || way_we),
            .we_i    (way_we),
            .addr_i  (set_addr),
            .wdata_i (fill_line_q),
            .rdata_o (way_lines[w])
        );
    end

    icache_checker #(
        .N_WAYS       (N_WAYS)
    ) u_checker (
        .tags_i       (way_tags),
        .valid_bits_i (valid_bits),
        .lines_i      (way_lines),
        .ppn_i        (mmu_q.ppn),
        .word_sel_i   (req_q.idx[icache_pkg::OFFSET_WIDTH-1 -: WSEL_W]),
        .hit_o        (hit_vec),
        .data_o       (fetch_word)
    );

endmodule

// File: tb.f
common/icache_pkg.sv
design/icache_sram.sv
icache/icache_checker.sv
icache/icache_replace.sv
icache/icache_ctrl.sv
icache/icache_top.sv
dv/icache_assert.sv
dv/icache_tb.sv
